// File: src/xaui_pkg.sv
package xaui_pkg;

  localparam int NUM_LANES = 4;

  // XGMII column code points used by the PCS
  localparam logic [7:0] IDLE_CODE  = 8'h07;
  localparam logic [7:0] COMMA_CODE = 8'hBC;
  localparam logic [7:0] ERROR_CODE = 8'hFE;
  localparam logic [7:0] FAULT_CODE = 8'h9C;

  // Byte i of data pairs with ctrl bit i
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  ctrl;
  } xgmii_word_t;

  // Lane k owns bytes 2k and 2k+1
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  charisk;
  } mgt_word_t;

  typedef struct packed {
    mgt_word_t   word;
    logic [7:0]  code_valid;
    logic [7:0]  comma;
    logic [NUM_LANES-1:0] lock;
  } mgt_rx_t;

endpackage

// File: src/link_ctrl_pkg.sv
package link_ctrl_pkg;

  // User side configuration, sampled every cycle
  typedef struct packed {
    logic [1:0] loopback;
    logic       powerdown;
  } link_config_t;

  // Status vector, lane_sync sits in the low bits
  typedef struct packed {
    logic       powerdown;
    logic       loopback_active;
    logic       rx_local_fault;
    logic       aligned;
    logic [3:0] lane_sync;
  } link_status_t;

  localparam link_status_t STATUS_RESET = '{
    powerdown:       1'b0,
    loopback_active: 1'b0,
    rx_local_fault:  1'b1,
    aligned:         1'b0,
    lane_sync:       4'b0000
  };

endpackage

// File: src/mgt_reset_seq.sv
`timescale 1ns/1ps

module mgt_reset_seq #(
  parameter int unsigned RESET_STRETCH = 15
) (
  input  logic                        clk,
  input  logic                        mgt_reset_stretch,
  input  link_ctrl_pkg::link_config_t cfg,
  output logic                        mgt_reset,
  output logic                        mgt_powerdown
);

  // One spare bit so a zero stretch still gives a legal width
  localparam int CNT_W = $clog2(RESET_STRETCH + 2);

  logic [CNT_W-1:0] stretch_cnt;

  // The counter runs down after reset and the MGT reset drops one edge after it empties
  always_ff @(posedge clk) begin
    if (mgt_reset_stretch) begin
      mgt_reset   <= 1'b1;
      stretch_cnt <= CNT_W'(RESET_STRETCH);
    end else if (stretch_cnt != '0) begin
      stretch_cnt <= stretch_cnt - 1'b1;
    end else begin
      mgt_reset <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mgt_reset_stretch) begin
      mgt_powerdown <= 1'b0;
    end else begin
      mgt_powerdown <= cfg.powerdown;
    end
  end

endmodule

// File: src/xaui_tx_encode.sv
`timescale 1ns/1ps

module xaui_tx_encode (
  input  logic                   clk,
  input  logic                   mgt_reset_stretch,
  input  xaui_pkg::xgmii_word_t  tx_in,
  output xaui_pkg::mgt_word_t    tx_out
);

  localparam int NUM_BYTES = 2 * xaui_pkg::NUM_LANES;

  xaui_pkg::mgt_word_t enc;

  always_comb begin
    enc = '0;
    for (int i = 0; i < NUM_BYTES; i++) begin
      enc.charisk[i] = tx_in.ctrl[i];
      if (tx_in.ctrl[i] && tx_in.data[8*i +: 8] == xaui_pkg::IDLE_CODE) begin
        // Idle goes out as K28.5 so the far end keeps its comma alignment
        enc.data[8*i +: 8] = xaui_pkg::COMMA_CODE;
      end else begin
        enc.data[8*i +: 8] = tx_in.data[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mgt_reset_stretch) begin
      tx_out.data    <= {NUM_BYTES{xaui_pkg::COMMA_CODE}};
      tx_out.charisk <= '1;
    end else begin
      tx_out <= enc;
    end
  end

endmodule

// File: src/xaui_lane_sync.sv
`timescale 1ns/1ps

module xaui_lane_sync #(
  parameter int unsigned SYNC_COMMAS = 4
) (
  input  logic                               clk,
  input  logic                               mgt_reset_stretch,
  input  logic                               mgt_reset,
  input  logic                               powerdown,
  input  xaui_pkg::mgt_rx_t                  rx_in,
  output xaui_pkg::mgt_rx_t                  rx_out,
  output logic [xaui_pkg::NUM_LANES-1:0]     lane_synced
);

  localparam int CNT_W = $clog2(SYNC_COMMAS + 1);

  logic [xaui_pkg::NUM_LANES-1:0] lane_good;
  logic [xaui_pkg::NUM_LANES-1:0] lane_comma;
  logic [CNT_W-1:0]               comma_cnt [xaui_pkg::NUM_LANES];

  // A lane cycle is good only when locked and both of its characters decoded
  always_comb begin
    for (int k = 0; k < xaui_pkg::NUM_LANES; k++) begin
      lane_good[k]  = rx_in.lock[k] && rx_in.code_valid[2*k] && rx_in.code_valid[2*k+1];
      lane_comma[k] = lane_good[k] && (rx_in.comma[2*k] || rx_in.comma[2*k+1]);
    end
  end

  always_ff @(posedge clk) begin
    if (mgt_reset_stretch || mgt_reset || powerdown) begin
      lane_synced <= '0;
      for (int k = 0; k < xaui_pkg::NUM_LANES; k++) begin
        comma_cnt[k] <= '0;
      end
    end else begin
      for (int k = 0; k < xaui_pkg::NUM_LANES; k++) begin
        if (!lane_good[k]) begin
          comma_cnt[k]   <= '0;
          lane_synced[k] <= 1'b0;
        end else if (lane_comma[k]) begin
          if (comma_cnt[k] == CNT_W'(SYNC_COMMAS - 1)) begin
            lane_synced[k] <= 1'b1;
          end else begin
            comma_cnt[k] <= comma_cnt[k] + 1'b1;
          end
        end else if (!lane_synced[k]) begin
          // Commas have to be consecutive while acquiring
          comma_cnt[k] <= '0;
        end
      end
    end
  end

  // Staged word lines up with the sync flags it produced
  always_ff @(posedge clk) begin
    rx_out <= rx_in;
  end

endmodule

// File: src/xaui_rx_decode.sv
`timescale 1ns/1ps

module xaui_rx_decode (
  input  logic                               clk,
  input  logic                               mgt_reset_stretch,
  input  xaui_pkg::mgt_rx_t                  rx_in,
  input  logic [xaui_pkg::NUM_LANES-1:0]     lane_synced,
  input  link_ctrl_pkg::link_config_t        cfg,
  output xaui_pkg::xgmii_word_t              rx_out,
  output link_ctrl_pkg::link_status_t        status
);

  localparam int NUM_BYTES = 2 * xaui_pkg::NUM_LANES;

  // Local fault ordered set for one 32-bit column, byte 0 in the low bits
  localparam logic [31:0] FAULT_COL_DATA = {8'h01, 8'h00, 8'h00, xaui_pkg::FAULT_CODE};
  localparam logic [3:0]  FAULT_COL_CTRL = 4'b0001;

  logic                  aligned;
  xaui_pkg::xgmii_word_t dec;

  assign aligned = &lane_synced;

  always_comb begin
    dec = '0;
    if (!aligned) begin
      dec.data = {2{FAULT_COL_DATA}};
      dec.ctrl = {2{FAULT_COL_CTRL}};
    end else begin
      for (int i = 0; i < NUM_BYTES; i++) begin
        if (!rx_in.code_valid[i]) begin
          dec.data[8*i +: 8] = xaui_pkg::ERROR_CODE;
          dec.ctrl[i]        = 1'b1;
        end else if (rx_in.word.charisk[i] &&
                     rx_in.word.data[8*i +: 8] == xaui_pkg::COMMA_CODE) begin
          dec.data[8*i +: 8] = xaui_pkg::IDLE_CODE;
          dec.ctrl[i]        = 1'b1;
        end else begin
          dec.data[8*i +: 8] = rx_in.word.data[8*i +: 8];
          dec.ctrl[i]        = rx_in.word.charisk[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mgt_reset_stretch) begin
      rx_out.data <= {2{FAULT_COL_DATA}};
      rx_out.ctrl <= {2{FAULT_COL_CTRL}};
      status      <= link_ctrl_pkg::STATUS_RESET;
    end else begin
      rx_out                 <= dec;
      status.lane_sync       <= lane_synced;
      status.aligned         <= aligned;
      status.rx_local_fault  <= !aligned;
      status.loopback_active <= cfg.loopback != 2'b00;
      status.powerdown       <= cfg.powerdown;
    end
  end

endmodule

// File: src/xaui_controller.sv
`timescale 1ns/1ps

module xaui_controller #(
  parameter int unsigned RESET_STRETCH = 15,
  parameter int unsigned SYNC_COMMAS   = 4
) (
  input  logic        clk,
  input  logic        mgt_reset_stretch,
  // Client side
  input  logic [63:0] xgmii_txd,
  input  logic [7:0]  xgmii_txc,
  output logic [63:0] xgmii_rxd,
  output logic [7:0]  xgmii_rxc,
  // MGT side
  output logic        mgt_reset,
  output logic [63:0] mgt_txdata,
  output logic [7:0]  mgt_txcharisk,
  input  logic [63:0] mgt_rxdata,
  input  logic [7:0]  mgt_rxcharisk,
  input  logic [7:0]  mgt_code_valid,
  input  logic [7:0]  mgt_code_comma,
  input  logic [3:0]  mgt_rxlock,
  input  logic [23:0] mgt_rx_status,
  output logic [3:0]  mgt_enable_align,
  output logic        mgt_en_chan_sync,
  output logic [1:0]  mgt_loopback,
  output logic        mgt_powerdown,
  output logic [3:0]  mgt_tx_reset,
  output logic [3:0]  mgt_rx_reset,
  // User side
  input  logic [1:0]  user_loopback,
  input  logic        user_powerdown,
  output logic [7:0]  link_status
);

  link_ctrl_pkg::link_config_t   cfg;
  link_ctrl_pkg::link_status_t   status;
  xaui_pkg::xgmii_word_t         tx_word;
  xaui_pkg::xgmii_word_t         rx_word;
  xaui_pkg::mgt_word_t           mgt_tx_word;
  xaui_pkg::mgt_rx_t             mgt_rx_word;
  xaui_pkg::mgt_rx_t             staged_rx;
  logic [xaui_pkg::NUM_LANES-1:0] lane_synced;

  assign cfg.loopback  = user_loopback;
  assign cfg.powerdown = user_powerdown;

  assign tx_word.data = xgmii_txd;
  assign tx_word.ctrl = xgmii_txc;

  assign mgt_rx_word.word.data    = mgt_rxdata;
  assign mgt_rx_word.word.charisk = mgt_rxcharisk;
  assign mgt_rx_word.code_valid   = mgt_code_valid;
  assign mgt_rx_word.comma        = mgt_code_comma;
  assign mgt_rx_word.lock         = mgt_rxlock;

  mgt_reset_seq #(
    .RESET_STRETCH(RESET_STRETCH)
  ) u_reset_seq (
    .clk               (clk),
    .mgt_reset_stretch (mgt_reset_stretch),
    .cfg               (cfg),
    .mgt_reset         (mgt_reset),
    .mgt_powerdown     (mgt_powerdown)
  );

  xaui_tx_encode u_tx_encode (
    .clk               (clk),
    .mgt_reset_stretch (mgt_reset_stretch),
    .tx_in             (tx_word),
    .tx_out            (mgt_tx_word)
  );

  xaui_lane_sync #(
    .SYNC_COMMAS(SYNC_COMMAS)
  ) u_lane_sync (
    .clk               (clk),
    .mgt_reset_stretch (mgt_reset_stretch),
    .mgt_reset         (mgt_reset),
    .powerdown         (mgt_powerdown),
    .rx_in             (mgt_rx_word),
    .rx_out            (staged_rx),
    .lane_synced       (lane_synced)
  );

  xaui_rx_decode u_rx_decode (
    .clk               (clk),
    .mgt_reset_stretch (mgt_reset_stretch),
    .rx_in             (staged_rx),
    .lane_synced       (lane_synced),
    .cfg               (cfg),
    .rx_out            (rx_word),
    .status            (status)
  );

  assign mgt_txdata    = mgt_tx_word.data;
  assign mgt_txcharisk = mgt_tx_word.charisk;
  assign xgmii_rxd     = rx_word.data;
  assign xgmii_rxc     = rx_word.ctrl;
  assign link_status   = status;

  // Comma alignment stays on for every lane that has not locked onto commas yet
  assign mgt_enable_align = ~lane_synced;
  assign mgt_en_chan_sync = &lane_synced;
  assign mgt_loopback     = user_loopback;
  assign mgt_tx_reset     = {4{mgt_reset}};
  assign mgt_rx_reset     = {4{mgt_reset}};

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic mgt_reset_stretch
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

  // Reset is released on a rising edge like the rest of the stimulus
  initial begin
    mgt_reset_stretch <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    mgt_reset_stretch <= 1'b0;
  end

endmodule

// File: sim/tb_xaui_controller.sv
`timescale 1ns/1ps

module tb_xaui_controller;

  localparam int    CLK_PERIOD    = 8;
  localparam int    RESET_STRETCH = 2;
  localparam int    SYNC_COMMAS   = 2;
  localparam int    MAX_LINES     = 64;
  localparam int    MIN_LINES     = 26;
  localparam string TEST_FILE     = "sim/xaui_tests.txt";

  // Field order matches the columns of the data file
  typedef struct packed {
    logic        ce;
    logic        pd;
    logic [1:0]  lb;
    logic [7:0]  txc;
    logic [63:0] txd;
    logic [3:0]  lock;
    logic [7:0]  valid;
    logic [7:0]  comma;
    logic [7:0]  rxk;
    logic [63:0] rxd;
    logic        flag_pad;
    logic        exp_rst;
    logic        exp_pd;
    logic        exp_chan;
    logic [3:0]  exp_align;
    logic [7:0]  exp_txk;
    logic [63:0] exp_txd;
    logic [7:0]  exp_status;
    logic [7:0]  exp_rxc;
    logic [63:0] exp_rxd;
  } test_line_t;

  logic        clk;
  logic        mgt_reset_stretch;
  logic [63:0] xgmii_txd;
  logic [7:0]  xgmii_txc;
  logic [63:0] xgmii_rxd;
  logic [7:0]  xgmii_rxc;
  logic        mgt_reset;
  logic [63:0] mgt_txdata;
  logic [7:0]  mgt_txcharisk;
  logic [63:0] mgt_rxdata;
  logic [7:0]  mgt_rxcharisk;
  logic [7:0]  mgt_code_valid;
  logic [7:0]  mgt_code_comma;
  logic [3:0]  mgt_rxlock;
  logic [23:0] mgt_rx_status;
  logic [3:0]  mgt_enable_align;
  logic        mgt_en_chan_sync;
  logic [1:0]  mgt_loopback;
  logic        mgt_powerdown;
  logic [3:0]  mgt_tx_reset;
  logic [3:0]  mgt_rx_reset;
  logic [1:0]  user_loopback;
  logic        user_powerdown;
  logic [7:0]  link_status;

  logic [$bits(test_line_t)-1:0] test_mem [MAX_LINES];
  int num_lines;
  int lines_checked;
  int error_count;
  bit load_done;

  tb_clock_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (2)
  ) u_clock_gen (
    .clk               (clk),
    .mgt_reset_stretch (mgt_reset_stretch)
  );

  xaui_controller #(
    .RESET_STRETCH (RESET_STRETCH),
    .SYNC_COMMAS   (SYNC_COMMAS)
  ) u_dut (.*);

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp, input int vec_no);
    error_count++;
    $display("CHECK FAILED vector %0d %s: got %h expected %h", vec_no, name, got, exp);
  endtask

  task automatic drive_inputs(input test_line_t t);
    xgmii_txd      <= t.txd;
    xgmii_txc      <= t.txc;
    mgt_rxdata     <= t.rxd;
    mgt_rxcharisk  <= t.rxk;
    mgt_code_valid <= t.valid;
    mgt_code_comma <= t.comma;
    mgt_rxlock     <= t.lock;
    user_loopback  <= t.lb;
    user_powerdown <= t.pd;
  endtask

  task automatic check_outputs(input test_line_t t, input int vec_no);
    if (mgt_reset !== t.exp_rst)
      report_mismatch("mgt_reset", 64'(mgt_reset), 64'(t.exp_rst), vec_no);
    if (mgt_tx_reset !== {4{t.exp_rst}})
      report_mismatch("mgt_tx_reset", 64'(mgt_tx_reset), 64'({4{t.exp_rst}}), vec_no);
    if (mgt_rx_reset !== {4{t.exp_rst}})
      report_mismatch("mgt_rx_reset", 64'(mgt_rx_reset), 64'({4{t.exp_rst}}), vec_no);
    if (mgt_powerdown !== t.exp_pd)
      report_mismatch("mgt_powerdown", 64'(mgt_powerdown), 64'(t.exp_pd), vec_no);
    // The loopback request is wired straight through to the MGT
    if (mgt_loopback !== t.lb)
      report_mismatch("mgt_loopback", 64'(mgt_loopback), 64'(t.lb), vec_no);
    if (mgt_txdata !== t.exp_txd)
      report_mismatch("mgt_txdata", mgt_txdata, t.exp_txd, vec_no);
    if (mgt_txcharisk !== t.exp_txk)
      report_mismatch("mgt_txcharisk", 64'(mgt_txcharisk), 64'(t.exp_txk), vec_no);
    if (mgt_enable_align !== t.exp_align)
      report_mismatch("mgt_enable_align", 64'(mgt_enable_align), 64'(t.exp_align), vec_no);
    if (mgt_en_chan_sync !== t.exp_chan)
      report_mismatch("mgt_en_chan_sync", 64'(mgt_en_chan_sync), 64'(t.exp_chan), vec_no);
    if (link_status !== t.exp_status)
      report_mismatch("link_status", 64'(link_status), 64'(t.exp_status), vec_no);
    if (xgmii_rxd !== t.exp_rxd)
      report_mismatch("xgmii_rxd", xgmii_rxd, t.exp_rxd, vec_no);
    if (xgmii_rxc !== t.exp_rxc)
      report_mismatch("xgmii_rxc", 64'(xgmii_rxc), 64'(t.exp_rxc), vec_no);
  endtask

  task automatic load_tests();
    int fd;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("The test data file %s could not be opened", TEST_FILE);
      error_count++;
    end else begin
      $fclose(fd);
      // A line of all ones cannot occur in the data, so it marks the end
      for (int i = 0; i < MAX_LINES; i++) begin
        test_mem[i] = '1;
      end
      $readmemh(TEST_FILE, test_mem);
      while (num_lines < MAX_LINES && test_mem[num_lines] != '1) begin
        num_lines++;
      end
      if (num_lines < MIN_LINES) begin
        $display("The test data file holds %0d lines but needs %0d", num_lines, MIN_LINES);
        error_count++;
      end
    end
  endtask

  initial begin : watchdog
    wait (load_done);
    #(CLK_PERIOD * (num_lines + 20));
    $display("Timeout after %0d ns, the test sequence did not complete",
             CLK_PERIOD * (num_lines + 20));
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    test_line_t t;
    xgmii_txd      <= '0;
    xgmii_txc      <= '0;
    mgt_rxdata     <= '0;
    mgt_rxcharisk  <= '0;
    mgt_code_valid <= '0;
    mgt_code_comma <= '0;
    mgt_rxlock     <= '0;
    mgt_rx_status  <= '0;
    user_loopback  <= '0;
    user_powerdown <= 1'b0;
    num_lines     = 0;
    lines_checked = 0;
    error_count   = 0;
    load_tests();
    load_done = 1'b1;
    // Each line drives one rising edge and is checked on the falling edge after it
    for (int i = 0; i < num_lines; i++) begin
      @(posedge clk);
      t = test_mem[i];
      drive_inputs(t);
      @(negedge clk);
      if (t.ce) begin
        check_outputs(t, i + 1);
        lines_checked++;
      end
    end
    $display("Vectors checked: %0d, errors: %0d", lines_checked, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: xaui_ctrl.f
src/xaui_pkg.sv
src/link_ctrl_pkg.sv
src/mgt_reset_seq.sv
src/xaui_tx_encode.sv
src/xaui_lane_sync.sv
src/xaui_rx_decode.sv
src/xaui_controller.sv
sim/tb_clock_gen.sv
sim/tb_xaui_controller.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_xaui_controller
FILELIST  = xaui_ctrl.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/xaui_tests.txt
// ctl{ce,pd,lb}_txc_txd_lock_valid_comma_rxk_rxd, one line per rising edge, then expected:
// flags{0,rst,pd,chan}_align_txk_txd_status_rxc_rxd after that edge
0_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_4_F_FF_BCBCBCBCBCBCBCBC_20_11_0100009C0100009C
8_00_0123456789ABCDEF_F_FF_FF_FF_BCBCBCBCBCBCBCBC_4_F_FF_BCBCBCBCBCBCBCBC_20_11_0100009C0100009C
8_01_55555555555555FB_F_FF_FF_FF_BCBCBCBCBCBCBCBC_4_F_00_0123456789ABCDEF_20_11_0100009C0100009C
8_FE_070707070707FD11_F_FF_FF_FF_BCBCBCBCBCBCBCBC_4_F_01_55555555555555FB_20_11_0100009C0100009C
8_00_0000000000000007_F_FF_0F_0F_44332211BCBCBCBC_0_F_FE_BCBCBCBCBCBCFD11_20_11_0100009C0100009C
8_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_0_F_00_0000000000000007_20_11_0100009C0100009C
8_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_0_C_FF_BCBCBCBCBCBCBCBC_20_11_0100009C0100009C
8_00_0123456789ABCDEF_F_FF_55_55_44BC33BC22BC11BC_1_0_FF_BCBCBCBCBCBCBCBC_23_11_0100009C0100009C
8_FF_0707070707070707_F_FF_00_01_0123456789ABCDFB_1_0_00_0123456789ABCDEF_1F_FF_0707070707070707
8_FF_0707070707070707_F_FF_00_01_0123456789ABCDFB_1_0_FF_BCBCBCBCBCBCBCBC_1F_55_4407330722071107
8_FF_0707070707070707_F_DF_00_01_0123456789ABCDFB_1_0_FF_BCBCBCBCBCBCBCBC_1F_01_0123456789ABCDFB
8_FE_070707070707FD11_F_FF_00_01_0123456789ABCDFB_0_4_FF_BCBCBCBCBCBCBCBC_1F_01_0123456789ABCDFB
8_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_0_4_FE_BCBCBCBCBCBCFD11_2B_11_0100009C0100009C
8_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_0_4_FF_BCBCBCBCBCBCBCBC_2B_11_0100009C0100009C
8_FF_0707070707070707_D_FF_FF_FF_BCBCBCBCBCBCBCBC_1_0_FF_BCBCBCBCBCBCBCBC_2B_11_0100009C0100009C
8_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_0_2_FF_BCBCBCBCBCBCBCBC_1F_FF_0707070707070707
8_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_0_2_FF_BCBCBCBCBCBCBCBC_2D_11_0100009C0100009C
A_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_1_0_FF_BCBCBCBCBCBCBCBC_2D_11_0100009C0100009C
A_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_1_0_FF_BCBCBCBCBCBCBCBC_5F_FF_0707070707070707
C_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_1_0_FF_BCBCBCBCBCBCBCBC_5F_FF_0707070707070707
C_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_3_0_FF_BCBCBCBCBCBCBCBC_9F_FF_0707070707070707
8_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_2_F_FF_BCBCBCBCBCBCBCBC_9F_FF_0707070707070707
8_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_0_F_FF_BCBCBCBCBCBCBCBC_20_11_0100009C0100009C
8_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_0_F_FF_BCBCBCBCBCBCBCBC_20_11_0100009C0100009C
8_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_1_0_FF_BCBCBCBCBCBCBCBC_20_11_0100009C0100009C
8_FF_0707070707070707_F_FF_FF_FF_BCBCBCBCBCBCBCBC_1_0_FF_BCBCBCBCBCBCBCBC_1F_FF_0707070707070707
